// File: Makefile
SOURCES := $(shell cat tb.f)
BIN := obj_dir/Vcamera_tb

.PHONY: all run clean

all: run

$(BIN): tb.f $(SOURCES)
	verilator --binary --assert --top-module camera_tb -f tb.f

run: $(BIN) verification/camera_golden.txt
	./$(BIN)

clean:
	rm -rf obj_dir

// File: tb.f
verilog/camera_pkg.sv
verilog/window_crop.sv
verilog/channel_meter.sv
verilog/camera_command.sv
verilog/camera_top.sv
verification/camera_tb.sv

// File: verification/camera_golden.txt
// Per frame 8 rows of 16 pixels, each pixel red green blue, 10-bit hex
// After each frame one line of expected red green blue averages
// frame 0
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 103 201 042 107 201 042 10b 201 042 10f 201 042 113 201 042 117 201 042 11b 201 042 11f 201 042 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 103 221 042 107 221 042 10b 221 042 10f 221 042 113 221 042 117 221 042 11b 221 042 11f 221 042 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 103 241 042 107 241 042 10b 241 042 10f 241 042 113 241 042 117 241 042 11b 241 042 11f 241 042 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 103 261 042 107 261 042 10b 261 042 10f 261 042 113 261 042 117 261 042 11b 261 042 11f 261 042 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff
043 08c 010
// frame 1
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3c3 000 001 3c3 020 001 3c3 040 001 3c3 060 001 3c3 080 001 3c3 0a0 001 3c3 0c0 001 3c3 0e0 001 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3c3 004 001 3c3 024 001 3c3 044 001 3c3 064 001 3c3 084 001 3c3 0a4 001 3c3 0c4 001 3c3 0e4 001 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3c3 008 001 3c3 028 001 3c3 048 001 3c3 068 001 3c3 088 001 3c3 0a8 001 3c3 0c8 001 3c3 0e8 001 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3c3 00c 001 3c3 02c 001 3c3 04c 001 3c3 06c 001 3c3 08c 001 3c3 0ac 001 3c3 0cc 001 3c3 0ec 001 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd 3fc 3fe 3fd
0f0 01d 000
// frame 2
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3ff 157 2aa 000 157 2aa 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0 3e0
07f 055 0aa

// File: verification/camera_tb.sv
module camera_tb;
    import camera_pkg::*;

    localparam int frame_rows     = 8;
    localparam int frame_cols     = 16;
    localparam int num_frames     = 3;
    localparam int frame_words    = frame_rows * frame_cols * num_channels + num_channels;
    localparam int golden_words   = num_frames * frame_words;
    localparam int reset_cycles   = 10;
    localparam int line_gap       = 2;
    localparam int pipe_latency   = 3; // Crop, meter and capture FSM stages
    localparam int command_count  = 32;
    localparam int command_cycles = 8;
    localparam int frame_cycles   = 2 + frame_rows * (frame_cols + line_gap) + pipe_latency;
    localparam int cycle_limit    =
        2 * (reset_cycles + num_frames * frame_cycles + command_count * command_cycles);

    logic          clock_spi_in;
    logic          mipi_byte_reset_n;
    pixel_stream_t pixel;
    logic [7:0]    op_code;
    logic          op_code_valid;
    logic [1:0]    operand_count;
    logic [7:0]    response;
    logic          response_valid;

    logic [11:0]   golden [golden_words]; // Bit 11 marks an entry the file never wrote
    int            cycle_count = 0;

    camera_top #(
        .X_START (4),
        .X_END   (12),
        .Y_START (2),
        .Y_END   (6)
    ) u_dut (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel),
        .op_code_i         (op_code),
        .op_code_valid_i   (op_code_valid),
        .operand_count_i   (operand_count),
        .response_o        (response),
        .response_valid_o  (response_valid)
    );

    initial clock_spi_in = 1'b0;
    always #20 clock_spi_in = ~clock_spi_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clock_spi_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic check_byte(input string test, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %02h actual %02h", test, expected, actual));
        end
    endtask

    task automatic check_state(input string test, input capture_state_e expected,
                               input capture_state_e actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %s actual %s",
                                test, expected.name(), actual.name()));
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected %0b actual %0b", test, expected, actual));
        end
    endtask

    function automatic logic [pixel_w-1:0] golden_pixel(input int f, input int y,
                                                        input int x, input int c);
        return golden[f * frame_words + (y * frame_cols + x) * num_channels + c][pixel_w-1:0];
    endfunction

    function automatic logic [meter_w-1:0] golden_average(input int f, input int c);
        return golden[f * frame_words + frame_rows * frame_cols * num_channels + c][meter_w-1:0];
    endfunction

    // Holds the opcode for hold cycles and checks every response it sees
    task automatic run_command(input cam_opcode_e op, input logic [1:0] count, input int hold,
                               input string test, input logic [7:0] expected);
        @(posedge clock_spi_in);
        op_code       <= op;
        op_code_valid <= 1'b1;
        operand_count <= count;
        for (int i = 0; i < hold; i++) begin
            @(posedge clock_spi_in);
            @(negedge clock_spi_in);
            check_flag({test, " valid"}, 1'b1, response_valid);
            if (op == op_status) begin
                check_state(test, capture_state_e'(expected[1:0]),
                            capture_state_e'(response[1:0]));
                check_byte({test, " upper bits"}, 8'h00, response & 8'hfc);
            end else begin
                check_byte(test, expected, response);
            end
        end
        @(posedge clock_spi_in);
        op_code_valid <= 1'b0;
        @(negedge clock_spi_in);
        check_flag({test, " valid after release"}, 1'b1, response_valid);
        @(negedge clock_spi_in);
        check_flag({test, " valid dropped"}, 1'b0, response_valid);
    endtask

    task automatic drive_frame(input int f, input bit probe_status);
        logic [num_channels-1:0][pixel_w-1:0] rgb;
        @(posedge clock_spi_in);
        pixel.frame_valid <= 1'b1;
        pixel.line_valid  <= 1'b0;
        for (int y = 0; y < frame_rows; y++) begin
            for (int x = 0; x < frame_cols; x++) begin
                for (int c = 0; c < num_channels; c++) begin
                    rgb[c] = golden_pixel(f, y, x, c);
                end
                @(posedge clock_spi_in);
                pixel.line_valid <= 1'b1;
                pixel.rgb        <= rgb;
            end
            @(posedge clock_spi_in);
            pixel.line_valid <= 1'b0;
            pixel.rgb        <= '0;
            @(posedge clock_spi_in);
            if (probe_status && y == frame_rows / 2) begin
                // Commands run in line blanking
                run_command(op_status, 2'd0, 1, "status mid-frame", {6'b000000, cap_running});
            end
        end
        @(posedge clock_spi_in);
        pixel.frame_valid <= 1'b0;
        repeat (pipe_latency) @(posedge clock_spi_in);
    endtask

    task automatic check_averages(input int f);
        for (int c = 0; c < num_channels; c++) begin
            run_command(op_metering, 2'(c), 1 + c, $sformatf("frame %0d metering %0d", f, c),
                        golden_average(f, c));
        end
        run_command(op_metering, 2'd3, 2, $sformatf("frame %0d metering 3", f), 8'h00);
    endtask

    initial begin
        pixel             <= '0;
        op_code           <= 8'h00;
        op_code_valid     <= 1'b0;
        operand_count     <= 2'd0;
        mipi_byte_reset_n <= 1'b0;
        for (int i = 0; i < golden_words; i++) begin
            golden[i] = {1'b1, 11'(i)};
        end
        $readmemh("verification/camera_golden.txt", golden);
        if (golden[golden_words-1][11]) begin
            abort_run("Golden file is missing or holds too few values");
        end
        repeat (reset_cycles) @(posedge clock_spi_in);
        mipi_byte_reset_n <= 1'b1;

        run_command(op_status, 2'd0, 1, "reset status", {6'b000000, cap_idle});
        for (int c = 0; c < 4; c++) begin
            run_command(op_metering, 2'(c), 1, $sformatf("reset metering %0d", c), 8'h00);
        end

        for (int f = 0; f < num_frames; f++) begin
            drive_frame(f, f == 1); // Capture runs over frame 1
            check_averages(f);
            if (f == 0) begin
                run_command(op_status, 2'd0, 1, "status before arm", {6'b000000, cap_idle});
                run_command(op_capture, 2'd0, 1, "capture arm", 8'h00);
                run_command(op_status, 2'd0, 1, "status armed", {6'b000000, cap_armed});
            end else begin
                run_command(op_status, 2'd0, 1, $sformatf("frame %0d status", f),
                            {6'b000000, cap_done});
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog/camera_command.sv
module camera_command (
    input  logic                                                clock_spi_in,
    input  logic                                                mipi_byte_reset_n,
    input  logic [7:0]                                          op_code_i,
    input  logic                                                op_code_valid_i,
    input  logic [1:0]                                          operand_count_i,
    input  logic                                                frame_start_i,
    input  camera_pkg::meter_result_t [camera_pkg::num_channels-1:0] results_i,
    output logic [7:0]                                          response_o,
    output logic                                                response_valid_o
);
    import camera_pkg::*;

    cam_opcode_e        opcode;
    capture_state_e     cap_state;
    capture_state_e     cap_state_next;
    logic [meter_w-1:0] selected_average;
    logic [7:0]         response_next;
    logic               capture_cmd;

    assign opcode      = cam_opcode_e'(op_code_i);
    assign capture_cmd = op_code_valid_i && (opcode == op_capture);

    // Operand count picks the colour, out of range reads as zero
    always_comb begin
        selected_average = '0;
        if (int'(operand_count_i) < num_channels) begin
            selected_average = results_i[operand_count_i].average;
        end
    end

    // Response byte for the current opcode
    always_comb begin
        case (opcode)
            op_capture: begin
                response_next = 8'h00;
            end
            op_status: begin
                response_next = {6'b000000, cap_state};
            end
            op_metering: begin
                response_next = 8'(selected_average);
            end
            default: begin
                response_next = 8'h00; // Unknown opcodes read back zero
            end
        endcase
    end

    // Capture FSM
    always_comb begin
        cap_state_next = cap_state;
        if (capture_cmd) begin
            cap_state_next = cap_armed; // Arming is allowed from any state
        end else begin
            case (cap_state)
                cap_armed: begin
                    if (frame_start_i) begin
                        cap_state_next = cap_running;
                    end
                end
                cap_running: begin
                    // Red publishes in the same cycle as green and blue
                    if (results_i[0].updated) begin
                        cap_state_next = cap_done;
                    end
                end
                default: begin
                    cap_state_next = cap_state;
                end
            endcase
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            cap_state        <= cap_idle;
            response_o       <= 8'h00;
            response_valid_o <= 1'b0;
        end else begin
            cap_state        <= cap_state_next;
            response_valid_o <= op_code_valid_i;
            if (op_code_valid_i) begin
                response_o <= response_next; // Holds last byte once idle
            end
        end
    end

    // Valid never outlives the command by more than a cycle
    valid_drops_a: assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        !op_code_valid_i |=> !response_valid_o);

endmodule

// File: verilog/camera_pkg.sv
package camera_pkg;

    // Sample and result widths
    localparam int pixel_w      = 10;
    localparam int meter_w      = 8;
    localparam int num_channels = 3;

    // Incoming sensor stream, rgb[0] red, rgb[1] green, rgb[2] blue
    typedef struct packed {
        logic                                  frame_valid;
        logic                                  line_valid;
        logic [num_channels-1:0][pixel_w-1:0] rgb;
    } pixel_stream_t;

    // One colour of a cropped pixel
    typedef struct packed {
        logic               valid;     // Pixel lies inside the window
        logic               frame_end; // Single cycle pulse
        logic [pixel_w-1:0] value;
    } channel_sample_t;

    // Per-frame metering output of one channel
    typedef struct packed {
        logic               updated;   // Pulses with each new average
        logic [meter_w-1:0] average;
    } meter_result_t;

    // Host command set
    typedef enum logic [7:0] {
        op_capture  = 8'h20,
        op_status   = 8'h21,
        op_metering = 8'h25
    } cam_opcode_e;

    // Capture progress as reported by op_status
    typedef enum logic [1:0] {
        cap_idle    = 2'd0,
        cap_armed   = 2'd1,
        cap_running = 2'd2,
        cap_done    = 2'd3
    } capture_state_e;

endpackage

// File: verilog/camera_top.sv
module camera_top #(
    parameter int X_START = 4,
    parameter int X_END   = 12,
    parameter int Y_START = 2,
    parameter int Y_END   = 6
) (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  camera_pkg::pixel_stream_t pixel_i,
    input  logic [7:0]                op_code_i,
    input  logic                      op_code_valid_i,
    input  logic [1:0]                operand_count_i,
    output logic [7:0]                response_o,
    output logic                      response_valid_o
);
    import camera_pkg::*;

    // Shift that turns the window sum into a mean
    localparam int AREA_LOG2 = $clog2((X_END - X_START) * (Y_END - Y_START));

    channel_sample_t [num_channels-1:0] samples;
    meter_result_t   [num_channels-1:0] results;
    logic                               frame_start;

    window_crop #(
        .X_START (X_START),
        .X_END   (X_END),
        .Y_START (Y_START),
        .Y_END   (Y_END)
    ) u_crop (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel_i),
        .samples_o         (samples),
        .frame_start_o     (frame_start)
    );

    // One meter per colour
    for (genvar c = 0; c < num_channels; c++) begin : g_meter
        channel_meter #(
            .AREA_LOG2 (AREA_LOG2)
        ) u_meter (
            .clock_spi_in      (clock_spi_in),
            .mipi_byte_reset_n (mipi_byte_reset_n),
            .sample_i          (samples[c]),
            .result_o          (results[c])
        );
    end

    camera_command u_command (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_count_i   (operand_count_i),
        .frame_start_i     (frame_start),
        .results_i         (results),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

endmodule

// File: verilog/channel_meter.sv
module channel_meter #(
    parameter int AREA_LOG2 = 5
) (
    input  logic                        clock_spi_in,
    input  logic                        mipi_byte_reset_n,
    input  camera_pkg::channel_sample_t sample_i,
    output camera_pkg::meter_result_t   result_o
);
    import camera_pkg::*;

    // Window holds at most 2**AREA_LOG2 pixels, so this never overflows
    localparam int sum_w = meter_w + AREA_LOG2;

    logic [sum_w-1:0]   sum_q;
    logic [sum_w-1:0]   sum_next;
    logic [meter_w-1:0] sample_msbs;
    logic [sum_w-1:0]   sum_shifted;

    // Only the top bits of each sample are metered
    assign sample_msbs = sample_i.value[pixel_w-1:pixel_w-meter_w];
    assign sum_next    = sum_q + sum_w'(sample_msbs);
    assign sum_shifted = sum_q >> AREA_LOG2;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            sum_q    <= '0;
            result_o <= '0;
        end else begin
            result_o.updated <= 1'b0;
            if (sample_i.frame_end) begin
                // Publish and start over for the next frame
                result_o.average <= sum_shifted[meter_w-1:0];
                result_o.updated <= 1'b1;
                sum_q            <= '0;
            end else if (sample_i.valid) begin
                sum_q <= sum_next;
            end
        end
    end

    // Frame end comes from a frame_valid fall, when no line can be active
    no_sample_at_end_a: assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        !(sample_i.valid && sample_i.frame_end));

endmodule

// File: verilog/window_crop.sv
module window_crop #(
    parameter int X_START = 4,
    parameter int X_END   = 12,
    parameter int Y_START = 2,
    parameter int Y_END   = 6
) (
    input  logic                                                   clock_spi_in,
    input  logic                                                   mipi_byte_reset_n,
    input  camera_pkg::pixel_stream_t                              pixel_i,
    output camera_pkg::channel_sample_t [camera_pkg::num_channels-1:0] samples_o,
    output logic                                                   frame_start_o
);
    import camera_pkg::*;

    localparam int pos_w = 12;

    logic [pos_w-1:0] x_count;
    logic [pos_w-1:0] y_count;
    logic [pos_w-1:0] y_pos;
    logic             frame_valid_q;
    logic             line_valid_q;
    logic             frame_rise;
    logic             frame_fall;
    logic             line_fall;
    logic             in_window;

    assign frame_rise = pixel_i.frame_valid && !frame_valid_q;
    assign frame_fall = !pixel_i.frame_valid && frame_valid_q;
    assign line_fall  = !pixel_i.line_valid && line_valid_q;

    // First line may open together with the frame
    assign y_pos = frame_rise ? '0 : y_count;

    assign in_window = pixel_i.line_valid &&
                       (x_count >= pos_w'(X_START)) && (x_count < pos_w'(X_END)) &&
                       (y_pos >= pos_w'(Y_START)) && (y_pos < pos_w'(Y_END));

    // Position counters
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            x_count       <= '0;
            y_count       <= '0;
        end else begin
            frame_valid_q <= pixel_i.frame_valid;
            line_valid_q  <= pixel_i.line_valid;
            if (pixel_i.line_valid) begin
                if (x_count != '1) begin
                    x_count <= x_count + 1'b1; // Saturates on very long lines
                end
            end else begin
                x_count <= '0;
            end
            if (frame_rise) begin
                y_count <= '0;
            end else if (line_fall && y_count != '1) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    // Registered samples, one per colour
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            samples_o     <= '0;
            frame_start_o <= 1'b0;
        end else begin
            frame_start_o <= frame_rise;
            for (int c = 0; c < num_channels; c++) begin
                samples_o[c].valid     <= in_window;
                samples_o[c].frame_end <= frame_fall;
                samples_o[c].value     <= pixel_i.rgb[c];
            end
        end
    end

    // Sensor must frame every line
    line_in_frame_a: assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        pixel_i.line_valid |-> pixel_i.frame_valid);

endmodule
